// File: design/cpu_regs_pkg.sv
// CPU register slice definitions
package cpu_regs_pkg;

	// Register codes in opcode field order
	typedef enum logic [2:0] {
		REG_B   = 3'd0,
		REG_C   = 3'd1,
		REG_D   = 3'd2,
		REG_E   = 3'd3,
		REG_H   = 3'd4,
		REG_L   = 3'd5,
		REG_HLM = 3'd6, // (HL), no memory here
		REG_A   = 3'd7
	} reg_sel_t;

	typedef enum logic [1:0] {PAIR_BC, PAIR_DE, PAIR_HL, PAIR_SP} pair_sel_t;

	typedef enum logic [1:0] {WR_MOVE, WR_IMM, WR_ALU, WR_IDU} wr_src_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND, ALU_XOR, ALU_OR, ALU_CP
	} alu_op_t;

	typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC} idu_op_t;

	typedef enum logic [1:0] {PC_HOLD, PC_ADV, PC_JUMP} pc_op_t;

	// Instruction classes after decode
	typedef enum logic [3:0] {
		CL_ILLEGAL, CL_MOVE, CL_LD_N, CL_LD_NN, CL_INC, CL_DEC, CL_ALU, CL_JP, CL_LD_SP_HL
	} op_class_t;

	localparam logic [7:0] OP_JP_NN    = 8'hC3;
	localparam logic [7:0] OP_LD_SP_HL = 8'hF9;

	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	localparam logic [APB_AW-1:0] ADDR_CMD    = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h04;
	localparam logic [APB_AW-1:0] ADDR_AF     = 8'h08;
	localparam logic [APB_AW-1:0] ADDR_BC     = 8'h0C;
	localparam logic [APB_AW-1:0] ADDR_DE     = 8'h10;
	localparam logic [APB_AW-1:0] ADDR_HL     = 8'h14;
	localparam logic [APB_AW-1:0] ADDR_SP     = 8'h18;
	localparam logic [APB_AW-1:0] ADDR_PC     = 8'h1C;
	localparam logic [APB_AW-1:0] ADDR_IR     = 8'h20;

	// Flag bit positions in F, low nibble unused
	localparam int FLAG_Z = 7;
	localparam int FLAG_N = 6;
	localparam int FLAG_H = 5;
	localparam int FLAG_C = 4;

endpackage

// File: design/reg_file.sv
// Eight-bit register file
module reg_file (
	input  logic                    clk,
	input  logic                    arst_n,
	input  cpu_regs_pkg::reg_sel_t  src_sel,
	input  cpu_regs_pkg::reg_sel_t  dst_sel,
	input  cpu_regs_pkg::pair_sel_t pair_sel,
	input  cpu_regs_pkg::wr_src_t   wr_src,
	input  logic                    wr_hi,
	input  logic                    reg_we,
	input  logic                    flag_we,
	input  logic [15:0]             imm,
	input  logic [7:0]              alu_result,
	input  logic [7:0]              alu_flags,
	input  logic [15:0]             idu_out,
	output logic [7:0]              src_data,
	output logic [15:0]             pair_data,
	output logic [7:0]              a_q,
	output logic [7:0]              f_q,
	output logic [7:0]              b_q,
	output logic [7:0]              c_q,
	output logic [7:0]              d_q,
	output logic [7:0]              e_q,
	output logic [7:0]              h_q,
	output logic [7:0]              l_q
);
	import cpu_regs_pkg::*;

	logic [7:0] wr_data;

	always_comb begin
		case (src_sel)
			REG_B:   src_data = b_q;
			REG_C:   src_data = c_q;
			REG_D:   src_data = d_q;
			REG_E:   src_data = e_q;
			REG_H:   src_data = h_q;
			REG_L:   src_data = l_q;
			REG_A:   src_data = a_q;
			default: src_data = 8'h00; // (HL) never reaches here
		endcase
	end

	always_comb begin
		case (pair_sel)
			PAIR_BC: pair_data = {b_q, c_q};
			PAIR_DE: pair_data = {d_q, e_q};
			PAIR_HL: pair_data = {h_q, l_q};
			default: pair_data = 16'h0000; // SP lives in addr_regs
		endcase
	end

	always_comb begin
		case (wr_src)
			WR_MOVE: wr_data = src_data;
			WR_IMM:  wr_data = wr_hi ? imm[15:8] : imm[7:0];
			WR_ALU:  wr_data = alu_result;
			default: wr_data = wr_hi ? idu_out[15:8] : idu_out[7:0];
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			a_q <= 8'h00;
			f_q <= 8'h00;
			b_q <= 8'h00;
			c_q <= 8'h00;
			d_q <= 8'h00;
			e_q <= 8'h00;
			h_q <= 8'h00;
			l_q <= 8'h00;
		end else begin
			if (reg_we) begin
				case (dst_sel)
					REG_B:   b_q <= wr_data;
					REG_C:   c_q <= wr_data;
					REG_D:   d_q <= wr_data;
					REG_E:   e_q <= wr_data;
					REG_H:   h_q <= wr_data;
					REG_L:   l_q <= wr_data;
					REG_A:   a_q <= wr_data;
					default: ;
				endcase
			end
			if (flag_we)
				f_q <= alu_flags; // Low nibble comes in as zero
		end
	end

endmodule

// File: design/alu8.sv
// Eight-bit ALU with SM83 flags
module alu8 (
	input  cpu_regs_pkg::alu_op_t alu_op,
	input  logic [7:0]            a_in,
	input  logic [7:0]            b_in,
	input  logic                  carry_in,
	output logic [7:0]            alu_result,
	output logic [7:0]            alu_flags
);
	import cpu_regs_pkg::*;

	logic       cin;
	logic [4:0] half;
	logic [8:0] full;
	logic       n_flag;
	logic       h_flag;
	logic       c_flag;

	assign cin = ((alu_op == ALU_ADC) || (alu_op == ALU_SBC)) ? carry_in : 1'b0;

	always_comb begin
		half = 5'd0;
		full = 9'd0;
		alu_result = 8'h00;
		n_flag = 1'b0;
		h_flag = 1'b0;
		c_flag = 1'b0;
		case (alu_op)
			ALU_ADD, ALU_ADC: begin
				half = {1'b0, a_in[3:0]} + {1'b0, b_in[3:0]} + {4'd0, cin};
				full = {1'b0, a_in} + {1'b0, b_in} + {8'd0, cin};
				alu_result = full[7:0];
				h_flag = half[4]; // Carry out of bit 3
				c_flag = full[8];
			end
			ALU_SUB, ALU_SBC, ALU_CP: begin
				half = {1'b0, a_in[3:0]} - {1'b0, b_in[3:0]} - {4'd0, cin};
				full = {1'b0, a_in} - {1'b0, b_in} - {8'd0, cin};
				alu_result = full[7:0]; // CP result is dropped by the sequencer
				n_flag = 1'b1;
				h_flag = half[4]; // Borrow wraps into bit 4
				c_flag = full[8];
			end
			ALU_AND: begin
				alu_result = a_in & b_in;
				h_flag = 1'b1;
			end
			ALU_XOR: alu_result = a_in ^ b_in;
			default: alu_result = a_in | b_in;
		endcase
	end

	always_comb begin
		alu_flags = 8'h00;
		alu_flags[FLAG_Z] = (alu_result == 8'h00);
		alu_flags[FLAG_N] = n_flag;
		alu_flags[FLAG_H] = h_flag;
		alu_flags[FLAG_C] = c_flag;
	end

endmodule

// File: design/addr_regs.sv
// Address registers and incrementer
module addr_regs (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [15:0]           imm,
	input  logic                  zw_we,
	input  logic [15:0]           pair_data,
	input  cpu_regs_pkg::idu_op_t idu_op,
	input  logic                  idu_from_sp,
	input  logic                  sp_we,
	input  logic                  sp_from_pair,
	input  cpu_regs_pkg::pc_op_t  pc_op,
	input  logic [1:0]            pc_len,
	output logic [15:0]           sp_q,
	output logic [15:0]           pc_q,
	output logic [15:0]           idu_out
);
	import cpu_regs_pkg::*;

	logic [15:0] zw_q;  // W in 15:8, Z in 7:0
	logic [15:0] idu_q;
	logic [15:0] idu_src;
	logic [15:0] sp_d;

	assign idu_src = idu_from_sp ? sp_q : pair_data;
	assign idu_out = idu_q;

	// SP source priority: HL copy, then IDU, else the immediate in Z/W
	assign sp_d = sp_from_pair ? pair_data :
	              idu_from_sp  ? idu_q     : zw_q;

	always_ff @(posedge clk) begin
		if (zw_we)
			zw_q <= imm;
	end

	always_ff @(posedge clk) begin
		case (idu_op)
			IDU_INC: idu_q <= idu_src + 16'd1; // Wraps FFFF to 0000
			IDU_DEC: idu_q <= idu_src - 16'd1;
			default: idu_q <= idu_q;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sp_q <= 16'hFFFE;
		end else if (sp_we) begin
			sp_q <= sp_d;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= 16'h0000;
		end else begin
			case (pc_op)
				PC_ADV:  pc_q <= pc_q + {14'd0, pc_len};
				PC_JUMP: pc_q <= zw_q;
				default: pc_q <= pc_q;
			endcase
		end
	end

endmodule

// File: design/seq_ctrl.sv
// APB slave and instruction sequencer
module seq_ctrl (
	input  logic                              clk,
	input  logic                              arst_n,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [cpu_regs_pkg::APB_AW-1:0]   paddr,
	input  logic [cpu_regs_pkg::APB_DW-1:0]   pwdata,
	output logic [cpu_regs_pkg::APB_DW-1:0]   prdata,
	output logic                              pready,
	output logic                              pslverr,
	input  logic [7:0]                        a_q,
	input  logic [7:0]                        f_q,
	input  logic [7:0]                        b_q,
	input  logic [7:0]                        c_q,
	input  logic [7:0]                        d_q,
	input  logic [7:0]                        e_q,
	input  logic [7:0]                        h_q,
	input  logic [7:0]                        l_q,
	input  logic [15:0]                       sp_q,
	input  logic [15:0]                       pc_q,
	output logic [15:0]                       imm,
	output cpu_regs_pkg::reg_sel_t            src_sel,
	output cpu_regs_pkg::reg_sel_t            dst_sel,
	output cpu_regs_pkg::pair_sel_t           pair_sel,
	output cpu_regs_pkg::wr_src_t             wr_src,
	output logic                              wr_hi,
	output logic                              reg_we,
	output logic                              flag_we,
	output cpu_regs_pkg::alu_op_t             alu_op,
	output cpu_regs_pkg::idu_op_t             idu_op,
	output logic                              idu_from_sp,
	output logic                              sp_we,
	output logic                              sp_from_pair,
	output cpu_regs_pkg::pc_op_t              pc_op,
	output logic [1:0]                        pc_len,
	output logic                              zw_we
);
	import cpu_regs_pkg::*;

	logic        access;
	logic        cmd_wr;
	logic        cmd_accept;
	logic        rd_hit;
	logic        busy_q;
	logic        illegal_q;
	logic [1:0]  step_q;
	logic [7:0]  ir_q;
	logic [15:0] imm_q;
	op_class_t   cls;
	logic [1:0]  n_steps;
	reg_sel_t    f_dst;
	reg_sel_t    f_src;
	pair_sel_t   f_pp;
	logic        step0;
	logic        step1;
	logic        step2;
	logic        last_step;

	assign access = psel && penable;
	assign cmd_wr = access && pwrite && (paddr == ADDR_CMD);
	assign cmd_accept = cmd_wr && !busy_q;
	assign pready = !(cmd_wr && busy_q); // Back-pressure until the core is idle
	assign pslverr = access && (pwrite ? (paddr != ADDR_CMD) : !rd_hit);

	always_comb begin
		rd_hit = 1'b1;
		case (paddr)
			ADDR_STATUS: prdata = {30'd0, illegal_q, busy_q};
			ADDR_AF:     prdata = {16'd0, a_q, f_q};
			ADDR_BC:     prdata = {16'd0, b_q, c_q};
			ADDR_DE:     prdata = {16'd0, d_q, e_q};
			ADDR_HL:     prdata = {16'd0, h_q, l_q};
			ADDR_SP:     prdata = {16'd0, sp_q};
			ADDR_PC:     prdata = {16'd0, pc_q};
			ADDR_IR:     prdata = {24'd0, ir_q};
			default: begin
				prdata = '0; // CMD is write only
				rd_hit = 1'b0;
			end
		endcase
	end

	// Z/W loads straight from the bus on the accepting edge
	assign imm = cmd_accept ? pwdata[23:8] : imm_q;
	assign zw_we = cmd_accept;

	assign f_dst = reg_sel_t'(ir_q[5:3]);
	assign f_src = reg_sel_t'(ir_q[2:0]);
	assign f_pp = pair_sel_t'(ir_q[5:4]);

	always_comb begin
		cls = CL_ILLEGAL;
		casez (ir_q)
			OP_JP_NN:    cls = CL_JP;
			OP_LD_SP_HL: cls = CL_LD_SP_HL;
			8'b01??????: cls = (f_dst == REG_HLM || f_src == REG_HLM) ? CL_ILLEGAL : CL_MOVE;
			8'b00???110: cls = (f_dst == REG_HLM) ? CL_ILLEGAL : CL_LD_N;
			8'b00??0001: cls = CL_LD_NN;
			8'b00??0011: cls = CL_INC;
			8'b00??1011: cls = CL_DEC;
			8'b10??????: cls = (f_src == REG_HLM) ? CL_ILLEGAL : CL_ALU;
			default:     cls = CL_ILLEGAL;
		endcase
	end

	always_comb begin
		case (cls)
			CL_LD_NN, CL_INC, CL_DEC, CL_JP: n_steps = 2'd2;
			default:                         n_steps = 2'd1;
		endcase
		case (cls)
			CL_LD_N:  pc_len = 2'd2;
			CL_LD_NN: pc_len = 2'd3;
			default:  pc_len = 2'd1;
		endcase
	end

	// Step 0 is the decode cycle, the IDU also runs there
	assign step0 = busy_q && (step_q == 2'd0);
	assign step1 = busy_q && (step_q == 2'd1);
	assign step2 = busy_q && (step_q == 2'd2);
	assign last_step = busy_q && (step_q == n_steps);

	assign pair_sel = (cls == CL_LD_SP_HL) ? PAIR_HL : f_pp;
	assign src_sel = f_src;
	assign alu_op = alu_op_t'(ir_q[5:3]);

	always_comb begin
		dst_sel = f_dst;
		wr_src = WR_MOVE;
		wr_hi = 1'b0;
		reg_we = 1'b0;
		flag_we = 1'b0;
		idu_op = IDU_NONE;
		idu_from_sp = 1'b0;
		sp_we = 1'b0;
		sp_from_pair = 1'b0;
		pc_op = PC_HOLD;
		if (last_step && cls != CL_ILLEGAL)
			pc_op = (cls == CL_JP) ? PC_JUMP : PC_ADV;
		case (cls)
			CL_MOVE: reg_we = step1;
			CL_LD_N: begin
				wr_src = WR_IMM;
				reg_we = step1;
			end
			CL_LD_NN: begin
				wr_src = WR_IMM;
				wr_hi = step1; // High byte first
				dst_sel = reg_sel_t'({ir_q[5:4], step2});
				reg_we = (f_pp != PAIR_SP) && (step1 || step2);
				sp_we = (f_pp == PAIR_SP) && step1;
			end
			CL_INC, CL_DEC: begin
				if (step0)
					idu_op = (cls == CL_INC) ? IDU_INC : IDU_DEC;
				idu_from_sp = (f_pp == PAIR_SP);
				wr_src = WR_IDU;
				wr_hi = step1;
				dst_sel = reg_sel_t'({ir_q[5:4], step2});
				reg_we = (f_pp != PAIR_SP) && (step1 || step2);
				sp_we = (f_pp == PAIR_SP) && step1;
			end
			CL_ALU: begin
				dst_sel = REG_A;
				wr_src = WR_ALU;
				reg_we = step1 && (alu_op != ALU_CP);
				flag_we = step1;
			end
			CL_LD_SP_HL: begin
				sp_we = step1;
				sp_from_pair = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (cmd_accept)
			imm_q <= pwdata[23:8];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			illegal_q <= 1'b0;
			step_q <= 2'd0;
			ir_q <= 8'h00;
		end else if (cmd_accept) begin
			busy_q <= 1'b1;
			step_q <= 2'd0;
			ir_q <= pwdata[7:0];
		end else if (busy_q) begin
			if (step0)
				illegal_q <= (cls == CL_ILLEGAL);
			if (last_step) begin
				busy_q <= 1'b0;
				step_q <= 2'd0;
			end else begin
				step_q <= step_q + 2'd1;
			end
		end
	end

endmodule

// File: design/cpu_regs_top.sv
// CPU register slice top level
module cpu_regs_top (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [cpu_regs_pkg::APB_AW-1:0] paddr,
	input  logic [cpu_regs_pkg::APB_DW-1:0] pwdata,
	output logic [cpu_regs_pkg::APB_DW-1:0] prdata,
	output logic                            pready,
	output logic                            pslverr
);
	import cpu_regs_pkg::*;

	logic [7:0]  a_q;
	logic [7:0]  f_q;
	logic [7:0]  b_q;
	logic [7:0]  c_q;
	logic [7:0]  d_q;
	logic [7:0]  e_q;
	logic [7:0]  h_q;
	logic [7:0]  l_q;
	logic [15:0] sp_q;
	logic [15:0] pc_q;
	logic [15:0] imm;
	logic [15:0] idu_out;
	logic [15:0] pair_data;
	logic [7:0]  src_data;
	logic [7:0]  alu_result;
	logic [7:0]  alu_flags;
	reg_sel_t    src_sel;
	reg_sel_t    dst_sel;
	pair_sel_t   pair_sel;
	wr_src_t     wr_src;
	alu_op_t     alu_op;
	idu_op_t     idu_op;
	pc_op_t      pc_op;
	logic        wr_hi;
	logic        reg_we;
	logic        flag_we;
	logic        idu_from_sp;
	logic        sp_we;
	logic        sp_from_pair;
	logic [1:0]  pc_len;
	logic        zw_we;

	seq_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.a_q(a_q), .f_q(f_q), .b_q(b_q), .c_q(c_q), .d_q(d_q), .e_q(e_q),
		.h_q(h_q), .l_q(l_q), .sp_q(sp_q), .pc_q(pc_q),
		.imm(imm), .src_sel(src_sel), .dst_sel(dst_sel), .pair_sel(pair_sel),
		.wr_src(wr_src), .wr_hi(wr_hi), .reg_we(reg_we), .flag_we(flag_we),
		.alu_op(alu_op), .idu_op(idu_op), .idu_from_sp(idu_from_sp), .sp_we(sp_we),
		.sp_from_pair(sp_from_pair), .pc_op(pc_op), .pc_len(pc_len), .zw_we(zw_we)
	);

	reg_file u_regs (
		.clk(clk), .arst_n(arst_n),
		.src_sel(src_sel), .dst_sel(dst_sel), .pair_sel(pair_sel), .wr_src(wr_src),
		.wr_hi(wr_hi), .reg_we(reg_we), .flag_we(flag_we), .imm(imm),
		.alu_result(alu_result), .alu_flags(alu_flags), .idu_out(idu_out),
		.src_data(src_data), .pair_data(pair_data),
		.a_q(a_q), .f_q(f_q), .b_q(b_q), .c_q(c_q), .d_q(d_q), .e_q(e_q),
		.h_q(h_q), .l_q(l_q)
	);

	alu8 u_alu (
		.alu_op(alu_op), .a_in(a_q), .b_in(src_data), .carry_in(f_q[FLAG_C]),
		.alu_result(alu_result), .alu_flags(alu_flags)
	);

	addr_regs u_addr (
		.clk(clk), .arst_n(arst_n),
		.imm(imm), .zw_we(zw_we), .pair_data(pair_data),
		.idu_op(idu_op), .idu_from_sp(idu_from_sp), .sp_we(sp_we),
		.sp_from_pair(sp_from_pair), .pc_op(pc_op), .pc_len(pc_len),
		.sp_q(sp_q), .pc_q(pc_q), .idu_out(idu_out)
	);

endmodule

// File: sim/cpu_regs_properties.sv
// APB and sequencing assertions
module cpu_regs_properties (
	input logic                            clk,
	input logic                            arst_n,
	input logic                            psel,
	input logic                            penable,
	input logic                            pwrite,
	input logic [cpu_regs_pkg::APB_AW-1:0] paddr,
	input logic                            pready,
	input logic                            pslverr,
	input logic                            busy
);
	import cpu_regs_pkg::*;

	logic       cmd_wr;
	logic [2:0] busy_cycles;

	assign cmd_wr = psel && penable && pwrite && (paddr == ADDR_CMD);

	// Cycles spent busy in the current command
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			busy_cycles <= 3'd0;
		else if (!busy)
			busy_cycles <= 3'd0;
		else if (busy_cycles != 3'd7)
			busy_cycles <= busy_cycles + 3'd1;
	end

	err_in_access: assert property (@(posedge clk) disable iff (!arst_n)
		pslverr |-> (psel && penable && pready))
		else $error("pslverr outside a completing access phase");

	busy_bounded: assert property (@(posedge clk) disable iff (!arst_n)
		busy_cycles <= 3'd3)
		else $error("busy stayed high longer than 3 cycles");

	cmd_held: assert property (@(posedge clk) disable iff (!arst_n)
		(cmd_wr && busy) |-> !pready)
		else $error("CMD write completed while busy");

endmodule

// File: sim/cpu_regs_tb.sv
// CPU register slice testbench
module cpu_regs_tb;
	import cpu_regs_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int N_LOADS = 30;
	localparam int N_ALU = 200;
	localparam int NUM_CMDS = N_LOADS + 3 * N_ALU + 40;
	localparam int TIMEOUT = NUM_CMDS * 40 * CLK_PERIOD;

	logic              clk;
	logic              arst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic              pready;
	logic              pslverr;

	// Reference copies indexed by register code
	logic [7:0]  m_reg [8];
	logic [7:0]  m_f;
	logic [7:0]  m_ir;
	logic [15:0] m_sp;
	logic [15:0] m_pc;
	logic        m_ill;
	int          seed = 32'he9b7;
	int          err_count = 0;
	event        check_req;
	event        check_ack;

	cpu_regs_top u_dut (
		.clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	bind seq_ctrl cpu_regs_properties u_props (
		.clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pready(pready), .pslverr(pslverr), .busy(busy_q)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout: the run did not finish within %0d time units", TIMEOUT);
		$display("TESTS FAILED");
		$fatal(1);
	end

	function automatic logic [15:0] pair_get(input logic [1:0] p);
		case (p)
			2'd0:    return {m_reg[0], m_reg[1]};
			2'd1:    return {m_reg[2], m_reg[3]};
			2'd2:    return {m_reg[4], m_reg[5]};
			default: return m_sp;
		endcase
	endfunction

	function automatic void pair_set(input logic [1:0] p, input logic [15:0] v);
		if (p == 2'd3) begin
			m_sp = v;
		end else begin
			m_reg[{p, 1'b0}] = v[15:8];
			m_reg[{p, 1'b1}] = v[7:0];
		end
	endfunction

	// SM83 ALU rules on plain integers
	function automatic void alu_model(input logic [2:0] op, input logic [7:0] b8);
		int         a;
		int         b;
		int         c;
		int         r;
		logic       nf;
		logic       hf;
		logic       cf;
		logic [7:0] res;
		a = int'(m_reg[7]);
		b = int'(b8);
		c = (op == 3'd1 || op == 3'd3) ? int'(m_f[4]) : 0;
		nf = 1'b0;
		hf = 1'b0;
		cf = 1'b0;
		r = 0;
		case (op)
			3'd0, 3'd1: begin
				r = a + b + c;
				hf = ((a % 16) + (b % 16) + c) > 15;
				cf = r > 255;
			end
			3'd2, 3'd3, 3'd7: begin
				r = a - b - c;
				hf = ((a % 16) - (b % 16) - c) < 0;
				cf = r < 0;
				nf = 1'b1;
			end
			3'd4: begin
				r = a & b;
				hf = 1'b1;
			end
			3'd5: r = a ^ b;
			default: r = a | b;
		endcase
		res = r[7:0];
		m_f = {res == 8'h00, nf, hf, cf, 4'h0};
		if (op != 3'd7)
			m_reg[7] = res; // CP keeps A
	endfunction

	// Expected state after one command
	function automatic void model_exec(input logic [7:0] op, input logic [15:0] nn);
		logic [2:0] d;
		logic [2:0] s;
		logic [1:0] p;
		logic       ill;
		d = op[5:3];
		s = op[2:0];
		p = op[5:4];
		ill = 1'b0;
		m_ir = op;
		if (op == 8'hC3) begin
			m_pc = nn;
		end else if (op == 8'hF9) begin
			m_sp = pair_get(2'd2);
			m_pc = m_pc + 16'd1;
		end else if (op[7:6] == 2'b01 && d != 3'd6 && s != 3'd6) begin
			m_reg[d] = m_reg[s];
			m_pc = m_pc + 16'd1;
		end else if (op[7:6] == 2'b00 && s == 3'd6 && d != 3'd6) begin
			m_reg[d] = nn[7:0];
			m_pc = m_pc + 16'd2;
		end else if (op[7:6] == 2'b00 && op[3:0] == 4'h1) begin
			pair_set(p, nn);
			m_pc = m_pc + 16'd3;
		end else if (op[7:6] == 2'b00 && (op[3:0] == 4'h3 || op[3:0] == 4'hB)) begin
			pair_set(p, op[3] ? pair_get(p) - 16'd1 : pair_get(p) + 16'd1);
			m_pc = m_pc + 16'd1;
		end else if (op[7:6] == 2'b10 && s != 3'd6) begin
			alu_model(d, m_reg[s]);
			m_pc = m_pc + 16'd1;
		end else begin
			ill = 1'b1; // Nothing else changes
		end
		m_ill = ill;
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		err_count++;
		$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		err_count++;
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check8(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_mismatch(name, {8'h00, got}, {8'h00, exp});
	endtask

	task automatic check16(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, {15'd0, got}, {15'd0, exp});
	endtask

	// Starts and ends on a falling edge with the bus idle
	task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] data, output logic [APB_DW-1:0] rdata,
			output logic err, output int waits);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = data;
		waits = 0;
		@(negedge clk);
		penable = 1'b1;
		forever begin
			#1;
			if (pready)
				break;
			waits++;
			@(negedge clk);
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
			output logic err, output int waits);
		logic [APB_DW-1:0] unused;
		apb_xfer(1'b1, addr, data, unused, err, waits);
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
			output logic err);
		int waits;
		apb_xfer(1'b0, addr, '0, data, err, waits);
		if (waits != 0)
			report_failure("An APB read was stalled by wait states");
	endtask

	task automatic wait_idle();
		logic [APB_DW-1:0] st;
		logic              e;
		do
			apb_read(ADDR_STATUS, st, e);
		while (st[0]);
	endtask

	task automatic request_check();
		-> check_req;
		@(check_ack);
	endtask

	task automatic run_cmd(input logic [7:0] op, input logic [15:0] nn);
		logic e;
		int   w;
		apb_write(ADDR_CMD, {8'h00, nn, op}, e, w);
		check_err("pslverr_cmd", e, 1'b0);
		model_exec(op, nn);
		wait_idle();
		request_check();
	endtask

	task automatic compare_state();
		logic [APB_DW-1:0] d;
		logic              e;
		apb_read(ADDR_STATUS, d, e);
		check8("status", d[7:0], {6'd0, m_ill, 1'b0});
		apb_read(ADDR_AF, d, e);
		check8("a", d[15:8], m_reg[7]);
		check8("f", d[7:0], m_f);
		apb_read(ADDR_BC, d, e);
		check16("bc", d[15:0], pair_get(2'd0));
		apb_read(ADDR_DE, d, e);
		check16("de", d[15:0], pair_get(2'd1));
		apb_read(ADDR_HL, d, e);
		check16("hl", d[15:0], pair_get(2'd2));
		apb_read(ADDR_SP, d, e);
		check16("sp", d[15:0], m_sp);
		apb_read(ADDR_PC, d, e);
		check16("pc", d[15:0], m_pc);
		apb_read(ADDR_IR, d, e);
		check8("ir", d[7:0], m_ir);
		check_err("pslverr_read", e, 1'b0);
	endtask

	initial begin
		forever begin
			@(check_req);
			compare_state();
			-> check_ack;
		end
	end

	function automatic logic [2:0] rand_reg();
		logic [2:0] r;
		do
			r = 3'($random(seed));
		while (r == 3'd6);
		return r;
	endfunction

	initial begin
		logic [APB_DW-1:0] d;
		logic              e;
		int                w;
		logic [2:0]        s;
		logic [1:0]        k;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		arst_n = 1'b0;
		foreach (m_reg[i])
			m_reg[i] = 8'h00;
		m_f = 8'h00;
		m_ir = 8'h00;
		m_sp = 16'hFFFE;
		m_pc = 16'h0000;
		m_ill = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		request_check();

		repeat (N_LOADS) begin
			k = 2'($unsigned($random(seed)) % 3);
			case (k)
				2'd0: run_cmd({2'b00, rand_reg(), 3'b110}, 16'($random(seed)));
				2'd1: run_cmd({2'b00, 2'($random(seed)), 4'h1}, 16'($random(seed)));
				default: run_cmd({2'b01, rand_reg(), rand_reg()}, 16'h0000);
			endcase
		end

		repeat (N_ALU) begin
			s = rand_reg();
			run_cmd({2'b00, 3'd7, 3'b110}, 16'($random(seed)));
			run_cmd({2'b00, s, 3'b110}, 16'($random(seed)));
			run_cmd({2'b10, 3'($random(seed)), s}, 16'h0000);
		end

		// Wrap at both ends for every pair including SP
		for (int p = 0; p < 4; p++) begin
			run_cmd({2'b00, 2'(p), 4'h1}, 16'hFFFF);
			run_cmd({2'b00, 2'(p), 4'h3}, 16'h0000);
			run_cmd({2'b00, 2'(p), 4'h1}, 16'h0000);
			run_cmd({2'b00, 2'(p), 4'hB}, 16'h0000);
		end
		run_cmd(8'h21, 16'($random(seed)));
		run_cmd(OP_LD_SP_HL, 16'h0000);
		run_cmd(OP_JP_NN, 16'($random(seed)));
		run_cmd(OP_JP_NN, 16'($random(seed)));

		run_cmd(8'h76, 16'h1234);
		run_cmd(8'h00, 16'h5678);
		apb_write(ADDR_AF, 32'h0000_FFFF, e, w);
		check_err("pslverr_ro_write", e, 1'b1);
		apb_read(8'h24, d, e);
		check_err("pslverr_unmapped", e, 1'b1);
		check16("prdata_unmapped", d[15:0], 16'h0000);
		apb_read(ADDR_CMD, d, e);
		check_err("pslverr_cmd_read", e, 1'b1);
		request_check();

		// Second CMD lands while the first is still running
		apb_write(ADDR_CMD, {8'h00, 16'h0000, 8'h03}, e, w);
		check_err("pslverr_cmd", e, 1'b0);
		model_exec(8'h03, 16'h0000);
		apb_write(ADDR_CMD, {8'h00, 16'h00A5, 8'h06}, e, w);
		check_err("pslverr_cmd_held", e, 1'b0);
		if (w == 0)
			report_failure("A CMD write issued while busy was not held off");
		model_exec(8'h06, 16'h00A5);
		wait_idle();
		request_check();

		if (err_count == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

endmodule

// File: cpu_regs_top.f
design/cpu_regs_pkg.sv
design/reg_file.sv
design/alu8.sv
design/addr_regs.sv
design/seq_ctrl.sv
design/cpu_regs_top.sv
sim/cpu_regs_properties.sv
sim/cpu_regs_tb.sv

// File: Makefile
# Verilator build for the CPU register slice
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= cpu_regs_tb
FILELIST  ?= cpu_regs_top.f
OBJDIR    ?= obj_dir
SIMBIN    ?= V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(SIMBIN)
	@out="$$(./$(OBJDIR)/$(SIMBIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
